// File: src.f
fpFormatPkg.sv
fpNormPkg.sv
fpDelay.sv
fpNormControl.sv
fpWholeReduce.sv
fpLeadZeroCount.sv
fpMantShift.sv
fpNormalize32.sv
tb_fpNormalize32.sv

// File: Makefile
# Verilator flow for the normalizer testbench

TOP := tb_fpNormalize32

.PHONY: all lint clean

# build, run, and pass only if the pass message shows up
all:
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation passed"

lint:
	verilator --lint-only -Wall --timing -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: tb_fpNormalize32.sv
/*
 * Testbench for the single precision normalizer. Drives directed and random
 * expanded values, predicts every result with a reference model and checks
 * it eight enabled cycles later, through stalls and after reset.
 */
`timescale 1ns/1ps

module tb_fpNormalize32 import fpFormatPkg::*, fpNormPkg::*; ();

	// expected outputs for one input
	typedef struct packed {
		fpN_t z;
		logic under;
		logic inexact;
	} normRes_t;

	// the enabled edge that captured the input, and what it must produce
	typedef struct packed {
		int issue;
		normRes_t res;
	} pending_t;

	logic clk, rst_i, ce_i, under_i;
	fpX_t x_i;
	fpN_t z_o;
	logic under_o, inexact_o;

	int seed = 32'h9d48_a443;
	int enEdges = 0;
	int checkCount = 0;
	int valueErrors = 0;
	int holdErrors = 0;
	int timeouts = 0;
	logic stallOn;
	pending_t pendQ[$];

	fpNormalize32 DUT (.clk, .rst_i, .ce_i, .x_i, .under_i, .z_o, .under_o, .inexact_o);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic int randBelow(int n);
		return int'({$random(seed)} % n);
	endfunction

	function automatic logic [FX:0] randSig();
		logic [63:0] raw;
		raw = {$random(seed), $random(seed)};
		return raw[FX:0];
	endfunction

	// ------------------------------------------------------------
	// expected result, worked out stage by stage in one step
	function automatic normRes_t refNorm(fpX_t x, logic under);
		normRes_t r;
		logic isInf, nearMax, cleared, lostAny;
		int inc, lz, lAmt, rAmt, negExp;
		logic [EMSB:0] e;
		logic [NSIG-1:0] red, one;
		logic [FX:0] lowMask;
		isInf = (x.exp == 8'hFF) && !under;
		nearMax = (x.exp >= 8'hFE) && !under;
		// the leading whole digit decides how far the exponent grows
		if (x.sig[FX] && !nearMax)
			inc = 2;
		else if (x.sig[FX-1] && !isInf)
			inc = 1;
		else
			inc = 0;
		e = x.exp + 8'(inc);
		// a finite value that grows into the all ones exponent is infinity
		cleared = (e == 8'hFF) && !isInf && !under;
		lowMask = (50'd1 << (FMSB + inc)) - 50'd1;
		red = '0;
		if (!cleared) begin
			red[NSIG-1:1] = x.sig[FX-2+inc -: NSIG-1];
			red[0] = |(x.sig & lowMask);
		end
		// leading zeros, an all zero significand counts the full width
		lz = NSIG;
		for (int i = NSIG - 1; i >= 0; i--) begin
			if (red[i] && lz == NSIG)
				lz = NSIG - 1 - i;
		end
		lAmt = (lz < int'(e)) ? lz : int'(e);
		negExp = -int'($signed(e));
		rAmt = (under && negExp > 0) ? ((negExp > NSIG) ? NSIG : negExp) : 0;
		r.z.sign = x.sign;
		r.under = under;
		r.inexact = red[0];
		one = 1;
		if (under) begin
			// bits pushed off the right end survive only as sticky
			lostAny = |(red & ((one << rAmt) - one));
			r.z.sig = red >> rAmt;
			r.z.sig[0] = r.z.sig[0] | lostAny;
		end else begin
			r.z.sig = red << lAmt;
		end
		if (isInf || cleared)
			r.z.exp = e;
		else if (under)
			r.z.exp = '0;
		else
			r.z.exp = e - 8'(lAmt);
		return r;
	endfunction

	task automatic reportMismatch(input string field, input logic [31:0] got,
			input logic [31:0] want);
		valueErrors++;
		$display("FAIL %0t ns: %s got %h expected %h", $time, field, got, want);
	endtask

	task automatic checkResult(input normRes_t want);
		checkCount++;
		assert (z_o.sign === want.z.sign)
		else reportMismatch("sign", 32'(z_o.sign), 32'(want.z.sign));
		assert (z_o.exp === want.z.exp)
		else reportMismatch("exponent", 32'(z_o.exp), 32'(want.z.exp));
		assert (z_o.sig === want.z.sig)
		else reportMismatch("significand", 32'(z_o.sig), 32'(want.z.sig));
		assert (under_o === want.under)
		else reportMismatch("under_o", 32'(under_o), 32'(want.under));
		assert (inexact_o === want.inexact)
		else reportMismatch("inexact_o", 32'(inexact_o), 32'(want.inexact));
	endtask

	// one input for one enabled edge, with a few stalled cycles ahead of it
	task automatic applyVector(input fpX_t x, input logic under);
		int stalls;
		pending_t ent;
		stalls = stallOn ? randBelow(3) : 0;
		repeat (stalls) begin
			@(posedge clk);
			#1;
			ce_i = 1'b0;
			// junk while ce_i is low, none of it may reach the output
			x_i.sig = randSig();
			x_i.exp = 8'(randBelow(256));
			under_i = 1'(randBelow(2));
		end
		@(posedge clk);
		#1;
		ce_i = 1'b1;
		x_i = x;
		under_i = under;
		ent.issue = enEdges + 1;
		ent.res = refNorm(x, under);
		pendQ.push_back(ent);
	endtask

	task automatic finishRun();
		$display("checked %0d results: %0d value errors, %0d hold errors, %0d timeouts",
			checkCount, valueErrors, holdErrors, timeouts);
		if (valueErrors + holdErrors + timeouts == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	// ------------------------------------------------------------
	// counts enabled edges and checks each result on its eighth one
	initial begin : compareProc
		logic edgeOn, edgeStall, lastUnder, lastInexact;
		fpN_t lastZ;
		pending_t ent;
		forever begin
			@(posedge clk);
			edgeOn = ce_i && !rst_i;
			edgeStall = !ce_i && !rst_i;
			if (edgeOn)
				enEdges++;
			@(negedge clk);
			if (edgeStall) begin
				assert (z_o === lastZ && under_o === lastUnder && inexact_o === lastInexact)
				else begin
					holdErrors++;
					$display("FAIL %0t ns: outputs changed while ce_i was low", $time);
				end
			end
			if (edgeOn && pendQ.size() > 0 && pendQ[0].issue + NORM_LATENCY - 1 == enEdges) begin
				ent = pendQ.pop_front();
				checkResult(ent.res);
			end
			lastZ = z_o;
			lastUnder = under_o;
			lastInexact = inexact_o;
		end
	end

	// ------------------------------------------------------------
	initial begin : stimulus
		fpX_t x;
		logic uf;
		int waited;
		// a nonzero underflow value flows with ce_i high all through reset
		// so the outputs read clear only if the reset clears them
		rst_i = 1'b1;
		ce_i = 1'b1;
		x_i = '0;
		x_i.exp = 8'hF0;
		x_i.sig = randSig();
		under_i = 1'b1;
		stallOn = 1'b0;
		repeat (8) @(posedge clk);
		#1;
		rst_i = 1'b0;
		assert (z_o === '0 && under_o === 1'b0 && inexact_o === 1'b0)
		else begin
			valueErrors++;
			$display("FAIL %0t ns: outputs not cleared by reset", $time);
		end
		// whole digit reduction with each of the three whole bits leading
		for (int lead = 0; lead < 3; lead++) begin
			repeat (20) begin
				x.sign = 1'(randBelow(2));
				x.exp = 8'(1 + randBelow(200));
				x.sig = randSig() >> lead;
				x.sig[FX-lead] = 1'b1;
				applyVector(x, 1'b0);
			end
		end
		// many leading zeros, small exponents stop the left shift early
		repeat (40) begin
			x.sign = 1'(randBelow(2));
			x.exp = 8'(randBelow(48));
			x.sig = randSig() >> (3 + randBelow(40));
			applyVector(x, 1'b0);
		end
		// negative exponents are denormalized by a right shift
		repeat (30) begin
			x.sign = 1'(randBelow(2));
			x.exp = 8'(-(1 + randBelow(40)));
			x.sig = randSig() >> randBelow(6);
			applyVector(x, 1'b1);
		end
		// infinity and NaN
		repeat (8) begin
			x.sign = 1'(randBelow(2));
			x.exp = 8'hFF;
			x.sig = randSig() >> randBelow(3);
			applyVector(x, 1'b0);
		end
		// finite values that grow into the all ones exponent
		repeat (12) begin
			x.sign = 1'(randBelow(2));
			x.exp = 8'hFD + 8'(randBelow(2));
			x.sig = randSig();
			x.sig[FX] = x.sig[FX] | (x.exp == 8'hFD);
			x.sig[FX-1] = 1'b1;
			applyVector(x, 1'b0);
		end
		// random mix with stalls in between
		stallOn = 1'b1;
		repeat (60) begin
			uf = (randBelow(4) == 0);
			x.sign = 1'(randBelow(2));
			x.exp = uf ? 8'(-(1 + randBelow(40))) : 8'(randBelow(256));
			x.sig = randSig() >> randBelow(12);
			applyVector(x, uf);
		end
		stallOn = 1'b0;
		// flush the pipeline until every result has been checked
		waited = 0;
		while (pendQ.size() > 0 && waited < 50) begin
			@(posedge clk);
			#1;
			ce_i = 1'b1;
			x_i = '0;
			under_i = 1'b0;
			waited++;
		end
		if (pendQ.size() > 0) begin
			timeouts++;
			$display("Timed out waiting for %0d results to leave the pipeline", pendQ.size());
		end
		finishRun();
	end

endmodule

// File: fpNormalize32.sv
/*
 * Single precision normalization unit, eight enabled cycles deep.
 * Takes the expanded result of an adder or multiplier and returns one whole
 * bit, the fraction and guard, round and sticky, plus underflow and inexact.
 */
`timescale 1ns/1ps

module fpNormalize32 import fpFormatPkg::*, fpNormPkg::*; (
	input  logic clk,
	input  logic rst_i,
	input  logic ce_i,
	input  fpX_t x_i,
	input  logic under_i,
	output fpN_t z_o,
	output logic under_o,
	output logic inexact_o
);

	expAdj_e adjOp;
	shiftCtl_t shiftCtl;
	logic [NSIG-1:0] redSig, outSig;
	logic redInexact, outSign;
	logic [4:0] lzCount;
	logic [EMSB:0] outExp;

	// ------------------------------------------------------------
	// exponent path and every decision
	fpNormControl uCtl (
		.clk, .rst_i, .ce_i,
		.exp_i(x_i.exp),
		.manTop_i(x_i.sig[FX:FX-1]),
		.under_i,
		.lzCount_i(lzCount),
		.adjOp_o(adjOp),
		.shiftCtl_o(shiftCtl),
		.exp_o(outExp),
		.under_o
	);

	// ------------------------------------------------------------
	// significand datapath
	fpWholeReduce uReduce (
		.clk, .rst_i, .ce_i,
		.sig_i(x_i.sig), .adjOp_i(adjOp),
		.sig_o(redSig), .inexact_o(redInexact)
	);

	fpLeadZeroCount uLzc (.clk, .rst_i, .ce_i, .sig_i(redSig), .count_o(lzCount));

	fpMantShift uShift (
		.clk, .rst_i, .ce_i,
		.sig_i(redSig), .shiftCtl_i(shiftCtl),
		.sig_o(outSig)
	);

	// sign is untouched and rides along, inexact is known from stage 4
	fpDelay #(.WID(1), .DEP(NORM_LATENCY)) uSign (
		.clk, .ce_i, .d_i(x_i.sign), .q_o(outSign)
	);
	fpDelay #(.WID(1), .DEP(NORM_LATENCY-4)) uInexact (
		.clk, .ce_i, .d_i(redInexact), .q_o(inexact_o)
	);

	assign z_o = '{sign: outSign, exp: outExp, sig: outSig};

endmodule

// File: fpMantShift.sv
/*
 * Significand shifter. Normalizes left or denormalizes right, keeps the
 * bits lost on a right shift as sticky, then picks the result by direction.
 */
`timescale 1ns/1ps

module fpMantShift import fpFormatPkg::*, fpNormPkg::*; (
	input  logic clk,
	input  logic rst_i,
	input  logic ce_i,
	input  logic [NSIG-1:0] sig_i,
	input  shiftCtl_t shiftCtl_i,
	output logic [NSIG-1:0] sig_o
);

	logic [NSIG-1:0] sig6, lostMask;
	logic [NSIG-1:0] sigL7, sigR7;
	logic sticky7;
	shiftDir_e dir7;

	// reduced significand arrives at stage 4, shift control at stage 6
	fpDelay #(.WID(NSIG), .DEP(2)) uSig (.clk, .ce_i, .d_i(sig_i), .q_o(sig6));

	// ones over the positions that fall off the right end
	assign lostMask = ~({NSIG{1'b1}} << shiftCtl_i.rAmt);

	// ------------------------------------------------------------
	// stage 7 both shifts are formed, the choice waits a cycle
	always_ff @(posedge clk) begin
		if (ce_i) begin
			sigL7 <= sig6 << shiftCtl_i.lAmt;
			sigR7 <= sig6 >> shiftCtl_i.rAmt;
			sticky7 <= |(sig6 & lostMask);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			dir7 <= SHIFT_LEFT;
		else if (ce_i)
			dir7 <= shiftCtl_i.dir;
	end

	// ------------------------------------------------------------
	// stage 8 select
	// on a denormal the lost bits join the existing sticky at bit 0
	always_ff @(posedge clk) begin
		if (rst_i) begin
			sig_o <= '0;
		end else if (ce_i) begin
			if (dir7 == SHIFT_RIGHT)
				sig_o <= {sigR7[NSIG-1:1], sigR7[0] | sticky7};
			else
				sig_o <= sigL7;
		end
	end

endmodule

// File: fpLeadZeroCount.sv
/*
 * Registered leading zero count of the reduced significand. Denormal
 * inputs can carry many leading zeros, so the count covers the full width.
 */
`timescale 1ns/1ps

module fpLeadZeroCount import fpFormatPkg::*; (
	input  logic clk,
	input  logic rst_i,
	input  logic ce_i,
	input  logic [NSIG-1:0] sig_i,
	output logic [4:0] count_o
);

	logic [4:0] lzc;

	// scan upward so the highest set bit is the last to write the count
	// an all zero significand gives the full width
	always_comb begin
		lzc = 5'(NSIG);
		for (int i = 0; i < NSIG; i++) begin
			if (sig_i[i])
				lzc = 5'(NSIG - 1 - i);
		end
	end

	always_ff @(posedge clk) begin
		if (rst_i)
			count_o <= '0;
		else if (ce_i)
			count_o <= lzc;
	end

endmodule

// File: fpWholeReduce.sv
/*
 * Whole digit reduction. Drops the extra whole digits of the expanded
 * significand and folds the low fraction bits into a sticky bit.
 */
`timescale 1ns/1ps

module fpWholeReduce import fpFormatPkg::*, fpNormPkg::*; (
	input  logic clk,
	input  logic rst_i,
	input  logic ce_i,
	input  logic [FX:0] sig_i,
	input  expAdj_e adjOp_i,
	output logic [NSIG-1:0] sig_o,
	output logic inexact_o
);

	// significand copy that waits for the control decision at stage 3
	logic [FX:0] sigPipe [3];
	logic [NSIG-2:0] win;
	logic lowBits;

	always_ff @(posedge clk) begin
		if (ce_i) begin
			sigPipe[0] <= sig_i;
			sigPipe[1] <= sigPipe[0];
			sigPipe[2] <= sigPipe[1];
		end
	end

	// ------------------------------------------------------------
	// window of whole, fraction, guard and round bits
	// everything below it becomes the sticky bit and also marks the result inexact
	always_comb begin
		case (adjOp_i)
			ADJ_TWO: begin
				win = sigPipe[2][FX:FMSB+2];
				lowBits = |sigPipe[2][FMSB+1:0];
			end
			ADJ_ONE: begin
				win = sigPipe[2][FX-1:FMSB+1];
				lowBits = |sigPipe[2][FMSB:0];
			end
			ADJ_NONE: begin
				win = sigPipe[2][FX-2:FMSB];
				lowBits = |sigPipe[2][FMSB-1:0];
			end
			default: begin
				// overflow to infinity, nothing of the significand survives
				win = '0;
				lowBits = 1'b0;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			sig_o <= '0;
			inexact_o <= 1'b0;
		end else if (ce_i) begin
			sig_o <= {win, lowBits};
			inexact_o <= lowBits;
		end
	end

endmodule

// File: fpNormControl.sv
/*
 * Normalizer control. Owns the exponent path: classifies the exponent, picks
 * how many whole digits to drop, works out the shift and forms the final exponent.
 */
`timescale 1ns/1ps

module fpNormControl import fpFormatPkg::*, fpNormPkg::*; (
	input  logic clk,
	input  logic rst_i,
	input  logic ce_i,
	input  logic [EMSB:0] exp_i,
	input  logic [1:0] manTop_i,
	input  logic under_i,
	input  logic [4:0] lzCount_i,
	output expAdj_e adjOp_o,
	output shiftCtl_t shiftCtl_o,
	output logic [EMSB:0] exp_o,
	output logic under_o
);

	// exponent and its class, carried together from stage 3 onwards
	typedef struct packed {
		logic [EMSB:0] exp;
		logic under;
		logic inf;
		logic zero;
	} expCls_t;

	logic inf1, near1, inf2, under2;
	logic [1:0] manTop1;
	logic [EMSB:0] exp2, expSum, expFin7;
	logic [1:0] incAmt;
	logic zeroHit;
	expAdj_e adj2;
	expCls_t cls3, cls5, cls6;
	logic signed [EMSB+1:0] negExp;
	logic [4:0] lAmtNext;
	logic [5:0] rAmtNext;
	shiftDir_e dir7;

	fpDelay #(.WID(2), .DEP(1)) uTop (.clk, .ce_i, .d_i(manTop_i), .q_o(manTop1));
	fpDelay #(.WID(EMSB+1), .DEP(2)) uExp (.clk, .ce_i, .d_i(exp_i), .q_o(exp2));
	fpDelay #(.WID(1), .DEP(2)) uUnder (.clk, .ce_i, .d_i(under_i), .q_o(under2));
	fpDelay #(.WID(1), .DEP(1)) uInf (.clk, .ce_i, .d_i(inf1), .q_o(inf2));
	// stage 3 class reaches the shift decision at stage 5
	fpDelay #(.WID($bits(expCls_t)), .DEP(2)) uCls (.clk, .ce_i, .d_i(cls3), .q_o(cls5));

	// ------------------------------------------------------------
	// stage 3 exponent increment, overflow to infinity clears the significand
	always_comb begin
		incAmt = (adj2 == ADJ_TWO) ? 2'd2 : (adj2 == ADJ_ONE) ? 2'd1 : 2'd0;
		expSum = exp2 + {{(EMSB-1){1'b0}}, incAmt};
		zeroHit = (expSum == EXP_MAX) && !inf2 && !under2;
	end

	// ------------------------------------------------------------
	// stage 6 shift amounts
	// an underflowed exponent is negative, its negation is the right shift
	always_comb begin
		negExp = -$signed({cls5.exp[EMSB], cls5.exp});
		lAmtNext = ({3'b000, lzCount_i} > cls5.exp) ? cls5.exp[4:0] : lzCount_i;
		if (!cls5.under || negExp <= 0)
			rAmtNext = '0;
		else if (negExp > NSIG)
			rAmtNext = 6'(NSIG);
		else
			rAmtNext = negExp[5:0];
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			inf1 <= 1'b0;
			near1 <= 1'b0;
			adj2 <= ADJ_NONE;
			cls3 <= '0;
			adjOp_o <= ADJ_NONE;
			cls6 <= '0;
			shiftCtl_o <= '0;
			expFin7 <= '0;
			dir7 <= SHIFT_LEFT;
			exp_o <= '0;
			under_o <= 1'b0;
		end else if (ce_i) begin
			// stage 1: infinity or NaN, and near enough to max that +2 cannot apply
			inf1 <= (exp_i == EXP_MAX) && !under_i;
			near1 <= (exp_i >= EXP_MAX - 8'd1) && !under_i;
			// stage 2: the leading whole digit sets how far the exponent grows
			if (!near1 && manTop1[1])
				adj2 <= ADJ_TWO;
			else if (!inf1 && manTop1[0])
				adj2 <= ADJ_ONE;
			else
				adj2 <= ADJ_NONE;
			// stage 3
			cls3 <= '{exp: expSum, under: under2, inf: inf2, zero: zeroHit};
			adjOp_o <= zeroHit ? ADJ_ZERO : adj2;
			// stage 6
			cls6 <= cls5;
			shiftCtl_o <= '{dir: cls5.under ? SHIFT_RIGHT : SHIFT_LEFT,
				lAmt: lAmtNext, rAmt: rAmtNext};
			// stage 7: infinity, NaN and a cleared significand keep their exponent
			if (cls6.inf || cls6.zero)
				expFin7 <= cls6.exp;
			else if (shiftCtl_o.dir == SHIFT_RIGHT)
				expFin7 <= '0;
			else
				expFin7 <= cls6.exp - {{(EMSB-4){1'b0}}, shiftCtl_o.lAmt};
			dir7 <= shiftCtl_o.dir;
			// stage 8 outputs
			exp_o <= expFin7;
			under_o <= (dir7 == SHIFT_RIGHT);
		end
	end

endmodule

// File: fpDelay.sv
/*
 * Clock-enabled delay line, used to keep side signals lined up with the
 * normalizer stages.
 */
`timescale 1ns/1ps

module fpDelay #(
	parameter int WID = 1,
	parameter int DEP = 1
) (
	input  logic clk,
	input  logic ce_i,
	input  logic [WID-1:0] d_i,
	output logic [WID-1:0] q_o
);

	// one entry per pipeline stage, oldest at the far end
	logic [WID-1:0] stages [DEP];

	always_ff @(posedge clk) begin
		if (ce_i) begin
			stages[0] <= d_i;
			for (int i = 1; i < DEP; i++) begin
				stages[i] <= stages[i-1];
			end
		end
	end

	assign q_o = stages[DEP-1];

endmodule

// File: fpNormPkg.sv
/*
 * Normalizer pipeline description: its latency and the codes that pass
 * from the control block to the significand datapath.
 */
package fpNormPkg;

	// enabled cycles from x_i to z_o
	localparam int NORM_LATENCY = 8;

	// how many whole digits are dropped from the expanded significand
	// ADJ_ZERO is used when the exponent overflows and the result is infinity
	typedef enum logic [1:0] {
		ADJ_NONE,
		ADJ_ONE,
		ADJ_TWO,
		ADJ_ZERO
	} expAdj_e;

	// left normalizes, right denormalizes an underflowed value
	typedef enum logic {
		SHIFT_LEFT,
		SHIFT_RIGHT
	} shiftDir_e;

	// ------------------------------------------------------------
	// shift control handed to the significand shifter
	typedef struct packed {
		shiftDir_e dir;
		logic [4:0] lAmt;
		logic [5:0] rAmt;
	} shiftCtl_t;

endpackage

// File: fpFormatPkg.sv
/*
 * Floating point format layouts: the expanded input that comes from an
 * adder or multiplier, and the normalized result with guard, round and sticky.
 */
package fpFormatPkg;

	// exponent is eight bits in single precision
	localparam int EMSB = 7;
	// top index of the 23-bit normalized fraction
	localparam int FMSB = 22;
	// top index of the expanded significand, three whole bits then fraction
	localparam int FX = 49;
	// all ones exponent marks infinity or NaN
	localparam logic [EMSB:0] EXP_MAX = 8'hFF;
	// one whole bit, 23 fraction bits, guard, round and sticky
	localparam int NSIG = 27;

	// ------------------------------------------------------------
	// expanded format as it leaves the arithmetic unit
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [FX:0] sig;
	} fpX_t;

	// normalized format, still ahead of rounding and packing
	typedef struct packed {
		logic sign;
		logic [EMSB:0] exp;
		logic [NSIG-1:0] sig;
	} fpN_t;

endpackage
